/* src/voice_pkg.sv */
package voice_pkg;

    // data path widths
    localparam int SAMPLE_W = 16;                       // signed audio sample
    localparam int VOL_W    = 4;                        // volume level
    localparam int PB_N     = 4;                        // number of pushbuttons
    localparam int KNOB_W   = 2;                        // quadrature knob lines

    localparam logic [VOL_W-1:0] VOL_MAX = 4'd15;       // loudest setting, no shift

    // gate compares a 17-bit magnitude so -32768 stays representable
    localparam logic [SAMPLE_W:0] NG_THRESHOLD = 17'd256;

    // effect clamps to +/- this value
    localparam logic signed [SAMPLE_W-1:0] EFFECT_CLIP = 16'sd8192;

    // knob phases in gray order, PH0 -> PH1 -> PH2 -> PH3 is clockwise
    typedef enum logic [KNOB_W-1:0] {
        PH0 = 2'b00,
        PH1 = 2'b01,
        PH2 = 2'b11,
        PH3 = 2'b10
    } quad_phase_t;

    // bit positions inside the pbs bus
    typedef enum logic [1:0] {
        BTN_PTT    = 2'd0,                              // push-to-talk, level
        BTN_MUTE   = 2'd1,                              // toggles mute
        BTN_EFFECT = 2'd2,                              // toggles clip effect
        BTN_NGATE  = 2'd3                               // toggles noise gate
    } button_t;

endpackage

/* src/ctrl_if.sv */
interface ctrl_if;

    logic [voice_pkg::VOL_W-1:0] volume;                // 0 quietest, 15 unshifted
    logic                        ptt;                   // push-to-talk held
    logic                        mute;                  // mute mode
    logic                        effect;                // clipping effect mode
    logic                        noise_gate;            // noise gate mode

    // decode side owns every level
    modport dec (
        output volume, ptt, mute, effect, noise_gate
    );

    // execute pipeline only shapes the sample
    modport exe (
        input volume, effect, noise_gate
    );

    // result stage gates the output
    modport res (
        input mute, ptt
    );

endinterface

/* src/synckey.sv */
module synckey (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [voice_pkg::PB_N-1:0]   pbs,       // raw pushbuttons
    input  logic [voice_pkg::KNOB_W-1:0] vol,       // raw quadrature knob
    ctrl_if.dec                          ctrl
);

    logic [voice_pkg::PB_N-1:0]   pbs_s1, pbs_s2;   // button synchronizer
    logic [voice_pkg::PB_N-1:0]   pbs_prev;         // last synced buttons
    logic [voice_pkg::PB_N-1:0]   rise;             // synced rising edges
    logic [voice_pkg::KNOB_W-1:0] vol_s1, vol_s2;   // knob synchronizer
    voice_pkg::quad_phase_t       ph_new, ph_old;   // knob phases, newer and older
    logic                         cw, acw;          // one step detected
    logic                         cw_q, acw_q;      // step registered
    logic [voice_pkg::VOL_W-1:0]  vol_q;            // volume level
    logic                         mute_q, effect_q, ngate_q, ptt_q;
    logic                         mute_d, effect_d, ngate_d;

    // two-flop synchronizers plus edge history
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pbs_s1   <= '0;
            pbs_s2   <= '0;
            pbs_prev <= '0;
            vol_s1   <= '0;
            vol_s2   <= '0;
        end else begin
            pbs_s1   <= pbs;
            pbs_s2   <= pbs_s1;
            pbs_prev <= pbs_s2;
            vol_s1   <= vol;
            vol_s2   <= vol_s1;
        end
    end

    assign rise = pbs_s2 & ~pbs_prev;               // press seen at second flop

    // one toggle per cycle, mute wins over effect wins over gate
    always_comb begin
        mute_d   = mute_q;
        effect_d = effect_q;
        ngate_d  = ngate_q;
        if (rise[voice_pkg::BTN_MUTE]) begin
            mute_d = ~mute_q;
        end else if (rise[voice_pkg::BTN_EFFECT]) begin
            effect_d = ~effect_q;
        end else if (rise[voice_pkg::BTN_NGATE]) begin
            ngate_d = ~ngate_q;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mute_q   <= 1'b0;
            effect_q <= 1'b0;
            ngate_q  <= 1'b0;
            ptt_q    <= 1'b0;
        end else begin
            mute_q   <= mute_d;
            effect_q <= effect_d;
            ngate_q  <= ngate_d;
            ptt_q    <= pbs_s2[voice_pkg::BTN_PTT];  // follows the button, no latch
        end
    end

    assign ph_new = voice_pkg::quad_phase_t'(vol_s1);
    assign ph_old = voice_pkg::quad_phase_t'(vol_s2);

    // direction from old phase to new phase, jumps of two count as nothing
    always_comb begin
        cw  = 1'b0;
        acw = 1'b0;
        case ({ph_old, ph_new})
            {voice_pkg::PH0, voice_pkg::PH1},
            {voice_pkg::PH1, voice_pkg::PH2},
            {voice_pkg::PH2, voice_pkg::PH3},
            {voice_pkg::PH3, voice_pkg::PH0}: cw  = 1'b1;
            {voice_pkg::PH0, voice_pkg::PH3},
            {voice_pkg::PH3, voice_pkg::PH2},
            {voice_pkg::PH2, voice_pkg::PH1},
            {voice_pkg::PH1, voice_pkg::PH0}: acw = 1'b1;
            default: ;                              // no move or invalid jump
        endcase
    end

    // step is registered so the knob lines up with the button path
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cw_q  <= 1'b0;
            acw_q <= 1'b0;
            vol_q <= '0;
        end else begin
            cw_q  <= cw;
            acw_q <= acw;
            if (cw_q && vol_q != voice_pkg::VOL_MAX) begin
                vol_q <= vol_q + 1'b1;              // saturate at top
            end else if (acw_q && vol_q != '0) begin
                vol_q <= vol_q - 1'b1;              // saturate at zero
            end
        end
    end

    assign ctrl.volume     = vol_q;
    assign ctrl.ptt        = ptt_q;
    assign ctrl.mute       = mute_q;
    assign ctrl.effect     = effect_q;
    assign ctrl.noise_gate = ngate_q;

    a_dir_excl: assert property (@(posedge clk) disable iff (rst)
        !(cw && acw));

    // no wrap and no double step
    a_vol_step: assert property (@(posedge clk) disable iff (rst)
        (vol_q != $past(vol_q)) |->
            (({1'b0, vol_q} == {1'b0, $past(vol_q)} + 5'd1) ||
             ({1'b0, vol_q} + 5'd1 == {1'b0, $past(vol_q)})));

    a_one_toggle: assert property (@(posedge clk) disable iff (rst)
        $countones({mute_q, effect_q, ngate_q} ^
                   $past({mute_q, effect_q, ngate_q})) <= 1);

endmodule

/* src/audio_proc.sv */
module audio_proc (
    input  logic                                clk,
    input  logic                                rst,
    input  logic signed [voice_pkg::SAMPLE_W-1:0] sample_in,
    input  logic                                sample_valid,
    ctrl_if.exe                                 ctrl,
    output logic signed [voice_pkg::SAMPLE_W-1:0] proc_sample,
    output logic                                proc_valid
);

    logic [voice_pkg::SAMPLE_W:0]          ext;       // sign-extended input, 17 bits
    logic [voice_pkg::SAMPLE_W:0]          mag;       // magnitude, fits -32768
    logic                                  gated;     // sample falls under the gate
    logic signed [voice_pkg::SAMPLE_W-1:0] clipped;   // effect applied
    logic signed [voice_pkg::SAMPLE_W-1:0] s1_next;   // stage 1 result
    logic signed [voice_pkg::SAMPLE_W-1:0] s1_data;
    logic                                  s1_valid;
    logic [voice_pkg::VOL_W-1:0]           shamt;     // attenuation in bits
    logic signed [voice_pkg::SAMPLE_W-1:0] s2_data;
    logic                                  s2_valid;

    assign ext = {sample_in[voice_pkg::SAMPLE_W-1], sample_in};
    assign mag = sample_in[voice_pkg::SAMPLE_W-1] ? -ext : ext;

    // gate looks at the raw sample, before any clipping
    assign gated = ctrl.noise_gate && (mag < voice_pkg::NG_THRESHOLD);

    always_comb begin
        if (sample_in > voice_pkg::EFFECT_CLIP) begin
            clipped = voice_pkg::EFFECT_CLIP;
        end else if (sample_in < -voice_pkg::EFFECT_CLIP) begin
            clipped = -voice_pkg::EFFECT_CLIP;
        end else begin
            clipped = sample_in;
        end
    end

    always_comb begin
        if (gated) begin
            s1_next = '0;                           // gate decided first
        end else if (ctrl.effect) begin
            s1_next = clipped;
        end else begin
            s1_next = sample_in;
        end
    end

    // volume 15 leaves the sample alone, volume 0 shifts by 15
    assign shamt = voice_pkg::VOL_MAX - ctrl.volume;

    // valid flags carry the pipeline state
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= sample_valid;
            s2_valid <= s1_valid;
        end
    end

    // sample data only moves with its valid
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            s1_data <= s1_next;
        end
        if (s1_valid) begin
            s2_data <= s1_data >>> shamt;           // arithmetic, keeps sign
        end
    end

    assign proc_sample = s2_data;
    assign proc_valid  = s2_valid;

    a_latency: assert property (@(posedge clk) disable iff (rst)
        proc_valid == $past(sample_valid, 2));

endmodule

/* src/audio_out.sv */
module audio_out (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [voice_pkg::SAMPLE_W-1:0] proc_sample,
    input  logic                                  proc_valid,
    ctrl_if.res                                   ctrl,
    output logic signed [voice_pkg::SAMPLE_W-1:0] sample_out,
    output logic                                  sample_out_valid,
    output logic                                  tx_active
);

    logic                                  silenced;  // mute without ptt
    logic signed [voice_pkg::SAMPLE_W-1:0] gated;     // sample after mute

    assign silenced = ctrl.mute && !ctrl.ptt;          // ptt overrides mute
    assign gated    = silenced ? '0 : proc_sample;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sample_out       <= '0;
            sample_out_valid <= 1'b0;
            tx_active        <= 1'b0;
        end else begin
            sample_out_valid <= proc_valid;         // one-cycle strobe
            if (proc_valid) begin
                sample_out <= gated;
                tx_active  <= (gated != '0);        // held until next sample
            end
        end
    end

    // a second strobe in a row needs two input strobes in a row
    a_strobe: assert property (@(posedge clk) disable iff (rst)
        (sample_out_valid && $past(sample_out_valid)) |->
            ($past(proc_valid) && $past(proc_valid, 2)));

endmodule

/* src/voice_top.sv */
module voice_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [voice_pkg::PB_N-1:0]            pbs,
    input  logic [voice_pkg::KNOB_W-1:0]          vol,
    input  logic signed [voice_pkg::SAMPLE_W-1:0] sample_in,
    input  logic                                  sample_valid,
    output logic signed [voice_pkg::SAMPLE_W-1:0] sample_out,
    output logic                                  sample_out_valid,
    output logic                                  tx_active,
    output logic [voice_pkg::VOL_W-1:0]           volume,      // status leds
    output logic                                  mute,
    output logic                                  effect,
    output logic                                  noise_gate,
    output logic                                  ptt
);

    logic signed [voice_pkg::SAMPLE_W-1:0] proc_sample;       // execute to result
    logic                                  proc_valid;

    ctrl_if ctrl_bus ();

    synckey u_synckey (
        .clk  (clk),
        .rst  (rst),
        .pbs  (pbs),
        .vol  (vol),
        .ctrl (ctrl_bus.dec)
    );

    audio_proc u_audio_proc (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .ctrl         (ctrl_bus.exe),
        .proc_sample  (proc_sample),
        .proc_valid   (proc_valid)
    );

    audio_out u_audio_out (
        .clk              (clk),
        .rst              (rst),
        .proc_sample      (proc_sample),
        .proc_valid       (proc_valid),
        .ctrl             (ctrl_bus.res),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .tx_active        (tx_active)
    );

    // control levels mirrored to pins
    assign volume     = ctrl_bus.volume;
    assign mute       = ctrl_bus.mute;
    assign effect     = ctrl_bus.effect;
    assign noise_gate = ctrl_bus.noise_gate;
    assign ptt        = ctrl_bus.ptt;

endmodule

/* tests/tb_clk.sv */
module tb_clk (
    output logic clk
);

    initial clk = 1'b0;

    always #4 clk = ~clk;                           // period 8

endmodule

/* tests/tb_checker.sv */
module tb_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic signed [15:0] sample_in,
    input  logic               sample_valid,
    input  logic signed [15:0] sample_out,
    input  logic               sample_out_valid,
    input  logic               tx_active,
    input  logic [3:0]         volume,
    input  logic               mute,
    input  logic               effect,
    input  logic               noise_gate,
    input  logic               ptt,
    input  logic [7:0]         exp_ctrl,        // {volume, mute, effect, gate, ptt}
    input  logic               step_end,        // last cycle of a pattern line
    input  int                 test_num,
    input  logic               run_done,
    output int                 error_count,
    output int                 check_count
);

    logic signed [15:0] exp_q[$];               // expected outputs in flight
    int                 due_q[$];               // cycle each one must show up
    int                 cycle;
    int                 cur_test;
    int                 test_checks;
    int                 test_errors;
    logic               closed;

    // gate on the raw value then clip then volume shift then mute
    function automatic logic signed [15:0] model_sample(input logic signed [15:0] s,
                                                        input logic [7:0] c);
        int v;
        v = s;
        if (c[1] && v > -256 && v < 256) begin
            v = 0;
        end else if (c[2]) begin
            if (v > 8192) v = 8192;
            else if (v < -8192) v = -8192;
        end
        v = v >>> (15 - c[7:4]);                // floor shift keeps the sign
        if (c[3] && !c[0]) v = 0;               // muted unless ptt held
        return v[15:0];
    endfunction

    task automatic compare(input string name, input int exp_v, input int act_v);
        check_count++;
        test_checks++;
        if (exp_v != act_v) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, exp_v, act_v);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic close_test();
        $display("test %0d finished: %0d checks, %0d errors",
                 cur_test, test_checks, test_errors);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        closed      = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (test_num != cur_test) begin
                if (cur_test != 0) close_test();
                cur_test    = test_num;
                test_checks = 0;
                test_errors = 0;
            end
            if (step_end) begin                 // controls settled by now
                compare("volume", exp_ctrl[7:4], volume);
                compare("mute", exp_ctrl[3], mute);
                compare("effect", exp_ctrl[2], effect);
                compare("noise_gate", exp_ctrl[1], noise_gate);
                compare("ptt", exp_ctrl[0], ptt);
            end
            if (sample_valid) begin
                exp_q.push_back(model_sample(sample_in, exp_ctrl));
                due_q.push_back(cycle + 3);     // result register loads two edges on
            end
            if (sample_out_valid) begin
                if (exp_q.size() == 0) begin
                    note_error("output strobe arrived with no sample sent");
                end else begin
                    if (due_q[0] != cycle) note_error("output strobe at the wrong cycle");
                    compare("sample_out", exp_q[0], sample_out);
                    compare("tx_active", exp_q[0] != 0, tx_active);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
                note_error("sample went in but no output strobe came out");
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (run_done && !closed) begin
                if (exp_q.size() != 0) note_error("samples still in the pipe at the end");
                close_test();
                closed = 1'b1;
            end
        end
    end

endmodule

/* tests/tb_top.sv */
module tb_top;

    localparam int MAX_LINES = 64;

    logic               clk;
    logic               rst;
    logic [3:0]         pbs;
    logic [1:0]         vol;
    logic signed [15:0] sample_in;
    logic               sample_valid;
    logic signed [15:0] sample_out;
    logic               sample_out_valid, tx_active;
    logic [3:0]         volume;
    logic               mute, effect, noise_gate, ptt;

    logic [7:0]         exp_ctrl;               // expected controls of the current line
    logic               step_end;
    logic               run_done;
    int                 test_num;
    int                 error_count, check_count;
    int                 n_lines, max_len, limit;

    int                 pat_test  [MAX_LINES];
    logic [3:0]         pat_pbs   [MAX_LINES];
    logic [1:0]         pat_knob  [MAX_LINES];
    int                 pat_turns [MAX_LINES];  // signed knob steps, + is clockwise
    logic [15:0]        pat_sample[MAX_LINES];
    logic               pat_valid [MAX_LINES];
    int                 pat_steps [MAX_LINES];  // cycles per knob position
    logic [7:0]         pat_ctrl  [MAX_LINES];

    tb_clk clk_gen (.clk(clk));

    voice_top uut (
        .clk(clk), .rst(rst), .pbs(pbs), .vol(vol),
        .sample_in(sample_in), .sample_valid(sample_valid),
        .sample_out(sample_out), .sample_out_valid(sample_out_valid),
        .tx_active(tx_active), .volume(volume), .mute(mute),
        .effect(effect), .noise_gate(noise_gate), .ptt(ptt)
    );

    tb_checker u_checker (
        .clk(clk), .rst(rst), .sample_in(sample_in), .sample_valid(sample_valid),
        .sample_out(sample_out), .sample_out_valid(sample_out_valid),
        .tx_active(tx_active), .volume(volume), .mute(mute), .effect(effect),
        .noise_gate(noise_gate), .ptt(ptt), .exp_ctrl(exp_ctrl),
        .step_end(step_end), .test_num(test_num), .run_done(run_done),
        .error_count(error_count), .check_count(check_count)
    );

    // gray knob order 00 01 11 10
    function automatic logic [1:0] knob_step(input logic [1:0] ph, input logic cw);
        case (ph)
            2'b00:   return cw ? 2'b01 : 2'b10;
            2'b01:   return cw ? 2'b11 : 2'b00;
            2'b11:   return cw ? 2'b10 : 2'b01;
            default: return cw ? 2'b00 : 2'b11;
        endcase
    endfunction

    task automatic load_patterns();
        int fd, r, t, turns, valid, steps, ev, em, ee, eg, ep;
        logic [3:0]     pb;
        logic [1:0]     kn;
        logic [15:0]    smp;
        reg [8*160-1:0] line_buf;
        fd = $fopen("tests/voice_patterns.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line_buf = '0;
            r = $fgets(line_buf, fd);
            r = $sscanf(line_buf, "%d %h %b %d %h %d %d %d %d %d %d %d",
                        t, pb, kn, turns, smp, valid, steps, ev, em, ee, eg, ep);
            if (r == 12) begin                  // comment and blank lines fall out here
                pat_test[n_lines]   = t;
                pat_pbs[n_lines]    = pb;
                pat_knob[n_lines]   = kn;
                pat_turns[n_lines]  = turns;
                pat_sample[n_lines] = smp;
                pat_valid[n_lines]  = valid[0];
                pat_steps[n_lines]  = steps;
                pat_ctrl[n_lines]   = {ev[3:0], em[0], ee[0], eg[0], ep[0]};
                if (steps * ((turns < 0) ? -turns : (turns == 0 ? 1 : turns)) > max_len)
                    max_len = steps * ((turns < 0) ? -turns : (turns == 0 ? 1 : turns));
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_line(input int i);
        int         reps;
        logic [1:0] ph;
        reps = (pat_turns[i] < 0) ? -pat_turns[i] : pat_turns[i];
        if (reps == 0) reps = 1;
        ph = pat_knob[i];                       // knob position when the line starts
        for (int r = 0; r < reps; r++) begin
            if (pat_turns[i] != 0) ph = knob_step(ph, pat_turns[i] > 0);
            for (int c = 0; c < pat_steps[i]; c++) begin
                @(negedge clk);
                test_num     = pat_test[i];
                exp_ctrl     = pat_ctrl[i];
                pbs          = pat_pbs[i];
                vol          = ph;
                sample_in    = pat_sample[i];
                sample_valid = pat_valid[i] && r == 0 && c == 0;   // one strobe per line
                step_end     = (r == reps - 1) && (c == pat_steps[i] - 1);
            end
        end
    endtask

    // watchdog, armed once the pattern length is known
    initial begin
        wait (limit > 0);
        #(limit);
        $display("timeout: run did not finish within %0d time units", limit);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        pbs          = '0;
        vol          = '0;
        sample_in    = '0;
        sample_valid = 1'b0;
        exp_ctrl     = '0;
        step_end     = 1'b0;
        run_done     = 1'b0;
        test_num     = 0;
        load_patterns();
        if (n_lines == 0) begin
            $display("no pattern lines could be read from tests/voice_patterns.txt");
            $display("*** FAILED ***");
        end else begin
            limit = n_lines * max_len * 8 + 200;
            repeat (10) @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                run_line(i);
            end
            @(negedge clk);
            step_end     = 1'b0;
            sample_valid = 1'b0;
            run_done     = 1'b1;
            @(negedge clk);                     // checker closes the last test
            $display("summary: %0d checks, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

endmodule

/* tests/voice_patterns.txt */
# test pbs(hex) knob(bin) turns sample(hex) valid steps | exp volume mute effect ngate ptt
# turns steps the knob from its phase, + clockwise; valid strobes once at the line start
1 0 00 0 4000 1 5 0 0 0 0 0
1 0 00 0 8000 1 5 0 0 0 0 0
2 0 00 8 0000 0 4 8 0 0 0 0
2 0 00 0 4000 1 5 8 0 0 0 0
2 0 00 10 0000 0 4 15 0 0 0 0
2 0 11 0 1234 1 5 15 0 0 0 0
2 0 11 -3 0000 0 4 12 0 0 0 0
2 0 01 0 0000 0 4 12 0 0 0 0
2 0 01 0 c000 1 5 12 0 0 0 0
2 0 01 -14 0000 0 4 0 0 0 0 0
2 0 10 0 7fff 1 5 0 0 0 0 0
2 0 10 15 0000 0 4 15 0 0 0 0
3 6 11 0 0000 0 4 15 1 0 0 0
3 0 11 0 0000 0 4 15 1 0 0 0
3 c 11 0 0000 0 4 15 1 1 0 0
3 0 11 0 0000 0 4 15 1 1 0 0
3 8 11 0 0000 0 4 15 1 1 1 0
3 0 11 0 0000 0 4 15 1 1 1 0
3 2 11 0 0000 0 4 15 0 1 1 0
3 0 11 0 0000 0 4 15 0 1 1 0
4 0 11 0 00ff 1 5 15 0 1 1 0
4 0 11 0 0100 1 5 15 0 1 1 0
4 0 11 0 7000 1 5 15 0 1 1 0
4 0 11 0 9000 1 5 15 0 1 1 0
4 4 11 0 0000 0 4 15 0 0 1 0
4 0 11 0 0000 0 4 15 0 0 1 0
4 0 11 0 7000 1 5 15 0 0 1 0
4 8 11 0 0000 0 4 15 0 0 0 0
4 0 11 0 0000 0 4 15 0 0 0 0
4 0 11 0 00ff 1 5 15 0 0 0 0
5 0 11 0 0400 1 5 15 0 0 0 0
5 2 11 0 0000 0 4 15 1 0 0 0
5 0 11 0 0000 0 4 15 1 0 0 0
5 0 11 0 0400 1 5 15 1 0 0 0
5 1 11 0 0000 0 4 15 1 0 0 1
5 1 11 0 0400 1 5 15 1 0 0 1
5 0 11 0 0000 0 4 15 1 0 0 0
5 0 11 0 0400 1 5 15 1 0 0 0
6 2 11 0 0000 0 4 15 0 0 0 0
6 0 11 0 0000 0 4 15 0 0 0 0
6 0 11 0 0400 1 1 15 0 0 0 0
6 0 11 0 0500 1 1 15 0 0 0 0
6 0 11 0 fa00 1 1 15 0 0 0 0
6 0 11 0 0300 1 5 15 0 0 0 0

/* tb.f */
src/voice_pkg.sv
src/ctrl_if.sv
src/synckey.sv
src/audio_proc.sv
src/audio_out.sv
src/voice_top.sv
tests/tb_clk.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: voice_chat

sources:
  - src/voice_pkg.sv
  - src/ctrl_if.sv
  - src/synckey.sv
  - src/audio_proc.sv
  - src/audio_out.sv
  - src/voice_top.sv
  - target: test
    files:
      - tests/tb_clk.sv
      - tests/tb_checker.sv
      - tests/tb_top.sv
